/* design/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  mem_op_t;  // funct3 of the load or store
    typedef logic [1:0]  wb_sel_t;

    // ----------------------------------------
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_AND   = 4'd2;
    localparam alu_op_t ALU_OR    = 4'd3;
    localparam alu_op_t ALU_XOR   = 4'd4;
    localparam alu_op_t ALU_SLT   = 4'd5;
    localparam alu_op_t ALU_SLTU  = 4'd6;
    localparam alu_op_t ALU_SLL   = 4'd7;
    localparam alu_op_t ALU_SRL   = 4'd8;
    localparam alu_op_t ALU_SRA   = 4'd9;
    localparam alu_op_t ALU_PASSB = 4'd10;  // lui

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam mem_op_t MEM_B  = 3'b000;
    localparam mem_op_t MEM_H  = 3'b001;
    localparam mem_op_t MEM_W  = 3'b010;
    localparam mem_op_t MEM_D  = 3'b011;
    localparam mem_op_t MEM_BU = 3'b100;
    localparam mem_op_t MEM_HU = 3'b101;
    localparam mem_op_t MEM_WU = 3'b110;

    localparam logic [2:0] BR_EQ = 3'b000;
    localparam logic [2:0] BR_NE = 3'b001;
    localparam logic [2:0] BR_LT = 3'b100;
    localparam logic [2:0] BR_GE = 3'b101;

    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_CSR = 2'd2;
    localparam wb_sel_t WB_PC4 = 2'd3;

    localparam logic [1:0] CMD_RW = 2'b01;
    localparam logic [1:0] CMD_RS = 2'b10;
    localparam logic [1:0] CMD_RC = 2'b11;

    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    localparam xlen_t CAUSE_ECALL_M = 64'd11;
    localparam xlen_t RESET_PC      = 64'h8000_0000;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        logic       reg_wr;
        logic       mem_rd;
        logic       mem_wr;
        mem_op_t    mem_op;
        logic [2:0] branch;    // branch funct3
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        wb_sel_t    wb_sel;
        logic       csr_en;
        logic [1:0] csr_cmd;
        logic       ecall;
        logic       mret;
        logic       ebreak;
        logic       illegal;
    } ctrl_t;

endpackage

/* design/cpu_decode.sv */
module cpu_decode
    import cpu_pkg::*;
(
    input  logic [31:0] instr,
    output ctrl_t       ctrl,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output reg_addr_t   rd,
    output xlen_t       imm,
    output csr_addr_t   csr_addr
);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    function automatic alu_op_t alu_of(input logic [2:0] fn, input logic alt);
        case (fn)
            3'b000:  alu_of = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_of = ALU_SLL;
            3'b010:  alu_of = ALU_SLT;
            3'b011:  alu_of = ALU_SLTU;
            3'b100:  alu_of = ALU_XOR;
            3'b101:  alu_of = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_of = ALU_OR;
            default: alu_of = ALU_AND;
        endcase
    endfunction

    assign opcode   = instr[6:0];
    assign f3       = instr[14:12];
    assign f7       = instr[31:25];
    assign rd       = instr[11:7];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign csr_addr = instr[31:20];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'd0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl   = '0;
        imm    = imm_i;
        ctrl.mem_op = f3;
        ctrl.branch = f3;
        case (opcode)
            OPC_LOAD: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_wr   = 1'b1;
                ctrl.mem_rd   = 1'b1;
                ctrl.wb_sel   = WB_MEM;
                ctrl.illegal  = (f3 == 3'b111);
            end
            OPC_STORE: begin
                imm           = imm_s;
                ctrl.b_is_imm = 1'b1;
                ctrl.mem_wr   = 1'b1;
                ctrl.illegal  = f3[2];  // no unsigned stores
            end
            OPC_OP_IMM: begin
                ctrl.alu_op   = alu_of(f3, (f3 == 3'b101) & instr[30]);
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_wr   = 1'b1;
                if (f3 == 3'b001)
                    ctrl.illegal = (instr[31:26] != 6'b000000);
                else if (f3 == 3'b101)
                    ctrl.illegal = (instr[31:26] != 6'b000000) && (instr[31:26] != 6'b010000);
            end
            OPC_OP: begin
                ctrl.alu_op  = alu_of(f3, instr[30]);
                ctrl.reg_wr  = 1'b1;
                ctrl.illegal = !((f7 == 7'b0000000) ||
                                 ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))));
            end
            OPC_BRANCH: begin
                imm            = imm_b;
                ctrl.is_branch = 1'b1;
                ctrl.illegal   = !((f3 == BR_EQ) || (f3 == BR_NE) ||
                                   (f3 == BR_LT) || (f3 == BR_GE));
            end
            OPC_JAL: begin
                imm         = imm_j;
                ctrl.is_jal = 1'b1;
                ctrl.reg_wr = 1'b1;
                ctrl.wb_sel = WB_PC4;
            end
            OPC_JALR: begin
                ctrl.is_jalr = 1'b1;
                ctrl.reg_wr  = 1'b1;
                ctrl.wb_sel  = WB_PC4;
                ctrl.illegal = (f3 != 3'b000);
            end
            OPC_LUI: begin
                imm           = imm_u;
                ctrl.alu_op   = ALU_PASSB;
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_wr   = 1'b1;
            end
            OPC_AUIPC: begin
                imm           = imm_u;
                ctrl.a_is_pc  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_wr   = 1'b1;
            end
            OPC_SYSTEM: begin
                if (f3 == 3'b000) begin
                    ctrl.ecall   = (instr == 32'h0000_0073);
                    ctrl.ebreak  = (instr == 32'h0010_0073);
                    ctrl.mret    = (instr == 32'h3020_0073);
                    ctrl.illegal = !(ctrl.ecall || ctrl.ebreak || ctrl.mret);
                end else begin
                    ctrl.csr_en  = 1'b1;  // csrrw / csrrs / csrrc
                    ctrl.csr_cmd = f3[1:0];
                    ctrl.reg_wr  = 1'b1;
                    ctrl.wb_sel  = WB_CSR;
                    ctrl.illegal = f3[2];  // immediate forms not supported
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

/* design/cpu_regfile.sv */
module cpu_regfile
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output xlen_t     src1,
    output xlen_t     src2,
    input  logic      wen,
    input  reg_addr_t rd,
    input  xlen_t     wdata
);
    xlen_t rf [1:31];  // x0 is not stored

    assign src1 = (rs1 == 5'd0) ? '0 : rf[rs1];
    assign src2 = (rs2 == 5'd0) ? '0 : rf[rs2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (wen && (rd != 5'd0)) begin
            rf[rd] <= wdata;
        end
    end

endmodule

/* design/cpu_exec.sv */
module cpu_exec
    import cpu_pkg::*;
(
    input  ctrl_t ctrl,
    input  xlen_t src1,
    input  xlen_t src2,
    input  xlen_t imm,
    input  xlen_t pc,
    output xlen_t alu_result,
    output xlen_t target,
    output logic  taken
);
    xlen_t      op_a;
    xlen_t      op_b;
    logic [5:0] shamt;
    logic       cond;

    assign op_a  = ctrl.a_is_pc  ? pc  : src1;
    assign op_b  = ctrl.b_is_imm ? imm : src2;
    assign shamt = op_b[5:0];

    // ----------------------------------------
    // alu
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:   alu_result = op_a + op_b;
            ALU_SUB:   alu_result = op_a - op_b;
            ALU_AND:   alu_result = op_a & op_b;
            ALU_OR:    alu_result = op_a | op_b;
            ALU_XOR:   alu_result = op_a ^ op_b;
            ALU_SLT:   alu_result = {63'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:  alu_result = {63'd0, op_a < op_b};
            ALU_SLL:   alu_result = op_a << shamt;
            ALU_SRL:   alu_result = op_a >> shamt;
            ALU_SRA:   alu_result = xlen_t'($signed(op_a) >>> shamt);
            ALU_PASSB: alu_result = op_b;
            default:   alu_result = '0;
        endcase
    end

    // ----------------------------------------
    // branch and jump
    always_comb begin
        case (ctrl.branch)
            BR_EQ:   cond = (src1 == src2);
            BR_NE:   cond = (src1 != src2);
            BR_LT:   cond = ($signed(src1) < $signed(src2));
            BR_GE:   cond = ($signed(src1) >= $signed(src2));
            default: cond = 1'b0;
        endcase
    end

    assign taken  = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && cond);
    assign target = ctrl.is_jalr ? ((src1 + imm) & ~64'd1) : (pc + imm);

endmodule

/* design/cpu_csr.sv */
module cpu_csr
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  ctrl_t     ctrl,
    input  csr_addr_t csr_addr,
    input  xlen_t     wdata,
    input  xlen_t     pc,
    input  logic      wen,
    output xlen_t     csr_rdata,
    output logic      csr_err,
    output logic      trap_jmp,
    output xlen_t     trap_pc
);
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mscratch;
    xlen_t new_val;
    logic  hit;

    // ----------------------------------------
    // read side
    always_comb begin
        hit = 1'b1;
        case (csr_addr)
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MCAUSE:   csr_rdata = mcause;
            CSR_MSCRATCH: csr_rdata = mscratch;
            default: begin
                csr_rdata = '0;
                hit       = 1'b0;
            end
        endcase
    end

    assign csr_err = ctrl.csr_en && !hit;

    always_comb begin
        case (ctrl.csr_cmd)
            CMD_RS:  new_val = csr_rdata | wdata;
            CMD_RC:  new_val = csr_rdata & ~wdata;
            default: new_val = wdata;  // CMD_RW
        endcase
    end

    // ----------------------------------------
    // write side where ecall takes the trap path
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (wen) begin
            if (ctrl.ecall) begin
                mepc   <= pc;
                mcause <= CAUSE_ECALL_M;
            end else if (ctrl.csr_en) begin
                case (csr_addr)
                    CSR_MTVEC:    mtvec    <= new_val;
                    CSR_MEPC:     mepc     <= new_val;
                    CSR_MCAUSE:   mcause   <= new_val;
                    CSR_MSCRATCH: mscratch <= new_val;
                    default:      ;
                endcase
            end
        end
    end

    assign trap_jmp = ctrl.ecall || ctrl.mret;
    assign trap_pc  = ctrl.ecall ? mtvec : mepc;

endmodule

/* design/cpu_writeback.sv */
module cpu_writeback
    import cpu_pkg::*;
(
    input  ctrl_t ctrl,
    input  xlen_t alu_result,
    input  xlen_t data_rd,
    input  xlen_t csr_rdata,
    input  xlen_t pc,
    input  xlen_t target,
    input  logic  taken,
    input  logic  trap_jmp,
    input  xlen_t trap_pc,
    input  logic  error,
    output xlen_t rd_wdata,
    output xlen_t next_pc
);
    xlen_t pc4;
    xlen_t load_val;

    assign pc4 = pc + 64'd4;

    always_comb begin
        case (ctrl.mem_op)
            MEM_B:   load_val = {{56{data_rd[7]}}, data_rd[7:0]};
            MEM_H:   load_val = {{48{data_rd[15]}}, data_rd[15:0]};
            MEM_W:   load_val = {{32{data_rd[31]}}, data_rd[31:0]};
            MEM_BU:  load_val = {56'd0, data_rd[7:0]};
            MEM_HU:  load_val = {48'd0, data_rd[15:0]};
            MEM_WU:  load_val = {32'd0, data_rd[31:0]};
            MEM_D:   load_val = data_rd;
            default: load_val = data_rd;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  rd_wdata = load_val;
            WB_CSR:  rd_wdata = csr_rdata;  // old csr value
            WB_PC4:  rd_wdata = pc4;
            default: rd_wdata = alu_result;
        endcase
    end

    always_comb begin
        if (error)            next_pc = pc4;
        else if (ctrl.ebreak) next_pc = pc;  // hold
        else if (trap_jmp)    next_pc = trap_pc;
        else if (taken)       next_pc = target;
        else                  next_pc = pc4;
    end

endmodule

/* design/cpu_core.sv */
module cpu_core
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] instr,
    input  xlen_t       data_rd,
    output xlen_t       pc,
    output xlen_t       addr,
    output xlen_t       data_wr,
    output logic        mem_wr,
    output logic        mem_rd,
    output mem_op_t     mem_op,
    output logic        error,
    output logic        done
);
    ctrl_t     ctrl;
    reg_addr_t rs1, rs2, rd;
    xlen_t     imm;
    csr_addr_t csr_addr;
    xlen_t     src1, src2;
    xlen_t     alu_result, target;
    logic      taken;
    xlen_t     csr_rdata, trap_pc;
    logic      trap_jmp, csr_err;
    xlen_t     rd_wdata, next_pc;
    logic      reg_wen, csr_wen;

    // ----------------------------------------
    assign error   = arst_n && (ctrl.illegal || csr_err);
    assign done    = arst_n && ctrl.ebreak;
    assign reg_wen = arst_n && ctrl.reg_wr && !error;
    assign csr_wen = arst_n && !error;

    assign addr    = alu_result;
    assign data_wr = src2;
    assign mem_op  = ctrl.mem_op;
    assign mem_wr  = arst_n && ctrl.mem_wr && !error;
    assign mem_rd  = arst_n && ctrl.mem_rd && !error;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) pc <= RESET_PC;
        else         pc <= next_pc;
    end

    // ----------------------------------------
    cpu_decode u_decode (
        .instr(instr), .ctrl(ctrl), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .csr_addr(csr_addr)
    );

    cpu_regfile u_regfile (
        .clk(clk), .arst_n(arst_n), .rs1(rs1), .rs2(rs2), .src1(src1), .src2(src2),
        .wen(reg_wen), .rd(rd), .wdata(rd_wdata)
    );

    cpu_exec u_exec (
        .ctrl(ctrl), .src1(src1), .src2(src2), .imm(imm), .pc(pc),
        .alu_result(alu_result), .target(target), .taken(taken)
    );

    cpu_csr u_csr (
        .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .csr_addr(csr_addr), .wdata(src1),
        .pc(pc), .wen(csr_wen), .csr_rdata(csr_rdata), .csr_err(csr_err),
        .trap_jmp(trap_jmp), .trap_pc(trap_pc)
    );

    cpu_writeback u_writeback (
        .ctrl(ctrl), .alu_result(alu_result), .data_rd(data_rd), .csr_rdata(csr_rdata),
        .pc(pc), .target(target), .taken(taken), .trap_jmp(trap_jmp), .trap_pc(trap_pc),
        .error(error), .rd_wdata(rd_wdata), .next_pc(next_pc)
    );

endmodule

/* testbench/cpu_core_tb.sv */
module cpu_core_tb
    import cpu_pkg::*;
;
    localparam int PROG_LEN   = 256;
    localparam int END_IDX    = 249;            // ebreak slot below the handler
    localparam int HANDLER    = 252;
    localparam int MAX_CYCLES = 4 * PROG_LEN;

    logic clk = 1'b0;
    logic arst_n;
    logic [31:0] instr;
    logic [31:0] rst_word;                     // fetched while in reset
    xlen_t data_rd, pc, addr, data_wr;
    logic mem_wr, mem_rd, error, done;
    mem_op_t mem_op;

    logic [31:0] rom [0:PROG_LEN-1];
    logic [7:0]  ram [0:255];                  // seen by the DUT
    logic [7:0]  mmem [0:255];                 // model copy
    xlen_t xr [0:31];
    xlen_t mpc, m_mtvec, m_mepc, m_mcause, m_mscratch;
    xlen_t e_addr, e_data;
    logic e_err, e_done, e_wr, e_rd;
    logic [31:0] lfsr = 32'h0b3c_1a5c;
    int cycles = 0;

    always #2 clk = ~clk;

    cpu_core dut0 (
        .clk(clk), .arst_n(arst_n), .instr(instr), .data_rd(data_rd), .pc(pc),
        .addr(addr), .data_wr(data_wr), .mem_wr(mem_wr), .mem_rd(mem_rd),
        .mem_op(mem_op), .error(error), .done(done)
    );

    // ----------------------------------------
    always_comb begin
        xlen_t off;
        off = pc - RESET_PC;
        if (!arst_n)
            instr = rst_word;
        else if (off < 64'd1024)
            instr = rom[off[9:2]];
        else
            instr = 32'h0000_0013;              // nop outside the rom
        for (int i = 0; i < 8; i++) begin
            data_rd[8*i +: 8] = ram[addr[7:0] + 8'(i)];
        end
    end

    always @(posedge clk) begin
        if (mem_wr) begin
            for (int i = 0; i < (1 << mem_op[1:0]); i++) begin
                ram[addr[7:0] + 8'(i)] <= data_wr[8*i +: 8];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: ebreak not reached after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped");
        end
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // every strobe stays low in reset whatever the word
    task automatic probe_reset(input logic [31:0] w, input string what);
        rst_word = w;
        #1 check({mem_wr, mem_rd, error, done}, 4'b0000, what);
    endtask

    // ----------------------------------------
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // galois step
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic reg_addr_t pick_reg();
        logic [2:0] v;
        v = 3'(take_bits(3));
        return (v == 3'd0) ? 5'd7 : {2'b00, v};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] im, input reg_addr_t r1,
                                          input logic [2:0] f3, input reg_addr_t rd,
                                          input logic [6:0] op);
        return {im, r1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] im, input reg_addr_t r2,
                                          input reg_addr_t r1, input logic [2:0] f3,
                                          input logic [6:0] op);
        return {im[11:5], r2, r1, f3, im[4:0], op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] im, input reg_addr_t r2,
                                          input reg_addr_t r1, input logic [2:0] f3);
        return {im[12], im[10:5], r2, r1, f3, im[4:1], im[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] im, input reg_addr_t rd);
        return {im[20], im[10:1], im[11], im[19:12], rd, OPC_JAL};
    endfunction

    // random program with short forward control flow only
    task automatic build_program();
        int idx, k;
        logic [2:0] f3;
        logic [1:0] w;
        logic [11:0] im;
        logic [3:0] kind;
        for (int i = 0; i < PROG_LEN; i++) rom[i] = 32'h0000_0013;
        rom[0] = {20'd0, 5'd8, OPC_AUIPC};          // x8 keeps the rom base for jalr
        rom[1] = enc_i(12'(HANDLER * 4), 5'd8, 3'b000, 5'd1, OPC_OP_IMM);
        rom[2] = enc_i(CSR_MTVEC, 5'd1, 3'b001, 5'd0, OPC_SYSTEM);
        idx = 3;
        while (idx < END_IDX) begin
            kind = 4'(take_bits(4));
            f3 = 3'(take_bits(3));
            k = 1 + take_bits(2);
            if (idx + k > END_IDX) k = END_IDX - idx;
            case (kind)
                0, 1: rom[idx] = {((f3 == 3'b000 || f3 == 3'b101) && take_bits(1)) ?
                                  7'b0100000 : 7'b0, pick_reg(), pick_reg(), f3, pick_reg(),
                                  OPC_OP};
                2, 3: begin
                    if (f3 == 3'b001) im = {6'd0, 6'(take_bits(6))};
                    else if (f3 == 3'b101)
                        im = {take_bits(1) ? 6'b010000 : 6'd0, 6'(take_bits(6))};
                    else im = 12'($signed(8'(take_bits(8))));
                    rom[idx] = enc_i(im, pick_reg(), f3, pick_reg(), OPC_OP_IMM);
                end
                4: rom[idx] = {20'(take_bits(20)), pick_reg(), OPC_LUI};
                5: rom[idx] = {16'd0, 4'(take_bits(4)), pick_reg(), OPC_AUIPC};
                6, 7, 8, 9: begin
                    w  = 2'(take_bits(2));
                    im = {4'd0, 8'(take_bits(8))} & ~12'((1 << w) - 1);  // aligned in the window
                    if (kind < 8)
                        rom[idx] = enc_i(im, 5'd0, {(w != 2'd3) && f3[0], w}, pick_reg(),
                                         OPC_LOAD);
                    else
                        rom[idx] = enc_s(im, pick_reg(), 5'd0, {1'b0, w}, OPC_STORE);
                end
                10: rom[idx] = enc_b(13'(4 * k), pick_reg(), pick_reg(), {f3[2], 1'b0, f3[0]});
                11: rom[idx] = enc_j(21'(4 * k), pick_reg());
                12: rom[idx] = enc_i(12'(4 * (idx + k)), 5'd8, 3'b000, pick_reg(), OPC_JALR);
                13: rom[idx] = enc_i(CSR_MSCRATCH, pick_reg(), (f3[1:0] == 2'b00) ? 3'b001 :
                                     {1'b0, f3[1:0]}, pick_reg(), OPC_SYSTEM);
                14: rom[idx] = enc_i(CSR_MCAUSE, 5'd0, 3'b010, pick_reg(), OPC_SYSTEM);
                default: begin
                    if (f3[1:0] == 2'd0) rom[idx] = 32'hffff_ffff;
                    else if (f3[1:0] == 2'd1)
                        rom[idx] = enc_i(12'h7c0, 5'd0, 3'b010, pick_reg(), OPC_SYSTEM);
                    else rom[idx] = 32'h0000_0073;          // ecall
                end
            endcase
            idx++;
        end
        rom[END_IDX]     = 32'h0010_0073;
        rom[HANDLER]     = enc_i(CSR_MEPC, 5'd0, 3'b010, 5'd5, OPC_SYSTEM);
        rom[HANDLER + 1] = enc_i(12'd4, 5'd5, 3'b000, 5'd5, OPC_OP_IMM);
        rom[HANDLER + 2] = enc_i(CSR_MEPC, 5'd5, 3'b001, 5'd0, OPC_SYSTEM);
        rom[HANDLER + 3] = 32'h3020_0073;
    endtask

    // ----------------------------------------
    // reference model stepping one instruction per call
    function automatic xlen_t alu(input logic [2:0] f3, input logic alt, input xlen_t a,
                                  input xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return xlen_t'($signed(a) < $signed(b));
            3'b011:  return xlen_t'(a < b);
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic wreg(input reg_addr_t rd, input xlen_t v);
        if (rd != 5'd0) xr[rd] = v;
    endtask

    task automatic model_step(input logic [31:0] w);
        reg_addr_t rd;
        xlen_t a, b, ii, npc, ea, v, old;
        logic [2:0] f3;
        rd = w[11:7];
        f3 = w[14:12];
        a  = xr[w[19:15]];
        b  = xr[w[24:20]];
        ii = {{52{w[31]}}, w[31:20]};
        npc = mpc + 64'd4;
        {e_err, e_done, e_wr, e_rd} = '0;
        case (w[6:0])
            OPC_OP:     wreg(rd, alu(f3, w[30], a, b));
            OPC_OP_IMM: wreg(rd, alu(f3, (f3 == 3'b101) && w[30], a, ii));
            OPC_LUI:    wreg(rd, {{32{w[31]}}, w[31:12], 12'd0});
            OPC_AUIPC:  wreg(rd, mpc + {{32{w[31]}}, w[31:12], 12'd0});
            OPC_JAL: begin
                npc = mpc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                wreg(rd, mpc + 64'd4);
            end
            OPC_JALR: begin
                npc = (a + ii) & ~64'd1;
                wreg(rd, mpc + 64'd4);
            end
            OPC_BRANCH: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b) ||
                    (f3 == 3'b100 && $signed(a) < $signed(b)) ||
                    (f3 == 3'b101 && $signed(a) >= $signed(b)))
                    npc = mpc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            OPC_LOAD: begin
                ea = a + ii;
                e_rd = 1'b1;
                for (int i = 0; i < 8; i++) v[8*i +: 8] = mmem[ea[7:0] + 8'(i)];
                case (f3)
                    3'b000:  v = {{56{v[7]}}, v[7:0]};
                    3'b001:  v = {{48{v[15]}}, v[15:0]};
                    3'b010:  v = {{32{v[31]}}, v[31:0]};
                    3'b100:  v = {56'd0, v[7:0]};
                    3'b101:  v = {48'd0, v[15:0]};
                    3'b110:  v = {32'd0, v[31:0]};
                    default: ;
                endcase
                wreg(rd, v);
            end
            OPC_STORE: begin
                e_addr = a + {{52{w[31]}}, w[31:25], w[11:7]};
                e_data = b;
                e_wr   = 1'b1;
                for (int i = 0; i < (1 << f3[1:0]); i++) mmem[e_addr[7:0] + 8'(i)] = b[8*i +: 8];
            end
            OPC_SYSTEM: begin
                if (w == 32'h0000_0073) begin
                    m_mepc = mpc;
                    m_mcause = 64'd11;
                    npc = m_mtvec;
                end else if (w == 32'h0010_0073) begin
                    e_done = 1'b1;
                    npc = mpc;
                end else if (w == 32'h3020_0073) npc = m_mepc;
                else begin
                    case (w[31:20])
                        CSR_MTVEC:    old = m_mtvec;
                        CSR_MEPC:     old = m_mepc;
                        CSR_MCAUSE:   old = m_mcause;
                        CSR_MSCRATCH: old = m_mscratch;
                        default:      e_err = 1'b1;     // no such csr
                    endcase
                    if (!e_err) begin
                        v = (f3[1:0] == 2'b01) ? a :
                            (f3[1:0] == 2'b10) ? (old | a) : (old & ~a);
                        case (w[31:20])
                            CSR_MTVEC:  m_mtvec = v;
                            CSR_MEPC:   m_mepc = v;
                            CSR_MCAUSE: m_mcause = v;
                            default:    m_mscratch = v;
                        endcase
                        wreg(rd, old);
                    end
                end
            end
            default: e_err = 1'b1;
        endcase
        mpc = npc;
    endtask

    // ----------------------------------------
    initial begin
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ram[i]  = 8'(i * 37) ^ 8'hc5;
            mmem[i] = 8'(i * 37) ^ 8'hc5;
        end
        for (int i = 0; i < 32; i++) xr[i] = '0;
        {m_mtvec, m_mepc, m_mcause, m_mscratch} = '0;
        mpc = RESET_PC;
        build_program();
        probe_reset(enc_s(12'd8, 5'd1, 5'd0, 3'b100, OPC_STORE), "store in reset");  // bad width
        @(posedge clk);
        #1 probe_reset(enc_i(12'd8, 5'd0, 3'b111, 5'd1, OPC_LOAD), "load in reset");  // bad width
        @(posedge clk);
        #1 probe_reset(32'h0010_0073, "ebreak in reset");
        @(posedge clk);
        #1 arst_n = 1'b1;
        @(negedge clk);
        check(pc, RESET_PC, "pc after reset");
        do begin
            check(pc, mpc, "pc");
            model_step(instr);
            check(error, e_err, "error");
            check(done, e_done, "done");
            check(mem_wr, e_wr, "mem_wr");
            check(mem_rd, e_rd, "mem_rd");
            if (e_wr) begin
                check(addr, e_addr, "store addr");
                check(mem_op, instr[14:12], "store mem_op");
                check(data_wr, e_data, "store data");
            end
            if (!e_done) @(negedge clk);
        end while (!e_done);
        @(negedge clk);
        check(pc, mpc, "pc held on ebreak");
        check(done, 1'b1, "done held");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* cpu_core.f */
design/cpu_pkg.sv
design/cpu_decode.sv
design/cpu_regfile.sv
design/cpu_exec.sv
design/cpu_csr.sv
design/cpu_writeback.sv
design/cpu_core.sv
testbench/cpu_core_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - design/cpu_pkg.sv
      - design/cpu_decode.sv
      - design/cpu_regfile.sv
      - design/cpu_exec.sv
      - design/cpu_csr.sv
      - design/cpu_writeback.sv
      - design/cpu_core.sv
  - target: simulation
    files:
      - testbench/cpu_core_tb.sv
